//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_world_clock
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
FILE_LIST ?= all.f

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx '\*\* PASS \*\*'

clean:
	rm -rf $(BUILD_DIR)

//--- adjust_if.sv
interface adjust_if;
    import clock_pkg::*;

    logic hour_up;
    logic hour_down;
    logic minute_up;
    logic minute_down;
    logic second_up;
    logic second_down;
    logic toggle_12h;
    logic country_valid;
    country_e country;
    logic run;            // Level, clock counts

    modport decoder (
        output hour_up, hour_down, minute_up, minute_down,
        output second_up, second_down, toggle_12h,
        output country_valid, country, run
    );

    modport keeper (
        input hour_up, hour_down, minute_up, minute_down,
        input second_up, second_down, toggle_12h,
        input country_valid, country, run
    );

endinterface

//--- all.f
clock_pkg.sv
adjust_if.sv
clock_state_if.sv
button_decoder.sv
time_keeper.sv
lcd_writer.sv
world_clock.sv
world_clock_checker.sv
tb_world_clock.sv

//--- button_decoder.sv
module button_decoder (
    input  logic clock,
    input  logic reset,
    input  logic [clock_pkg::MODE_WIDTH-1:0] mode,
    input  logic [clock_pkg::BUTTON_WIDTH-1:0] button,
    adjust_if.decoder adj
);
    import clock_pkg::*;

    logic [BUTTON_WIDTH-1:0] button_q;
    logic [BUTTON_WIDTH-1:0] rise_q;
    logic set_mode;
    logic country_mode;
    logic single;
    logic set_hit;
    logic country_hit;

    assign set_mode     = mode[MODE_SET_BIT];
    assign country_mode = !mode[MODE_SET_BIT] && mode[MODE_COUNTRY_BIT];

    // Several buttons at once count as nothing
    assign single      = $onehot(rise_q);
    assign set_hit     = set_mode && single;
    assign country_hit = country_mode && single;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            button_q <= '0;
            rise_q   <= '0;
        end else begin
            button_q <= button;
            rise_q   <= button & ~button_q; // One cycle per press
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            adj.run           <= 1'b0;
            adj.hour_up       <= 1'b0;
            adj.hour_down     <= 1'b0;
            adj.minute_up     <= 1'b0;
            adj.minute_down   <= 1'b0;
            adj.second_up     <= 1'b0;
            adj.second_down   <= 1'b0;
            adj.toggle_12h    <= 1'b0;
            adj.country_valid <= 1'b0;
            adj.country       <= JPN;
        end else begin
            adj.run           <= !set_mode && !country_mode;
            adj.hour_up       <= set_hit && rise_q[BTN_HOUR_UP];
            adj.hour_down     <= set_hit && rise_q[BTN_HOUR_DOWN];
            adj.minute_up     <= set_hit && rise_q[BTN_MIN_UP];
            adj.minute_down   <= set_hit && rise_q[BTN_MIN_DOWN];
            adj.second_up     <= set_hit && rise_q[BTN_SEC_UP];
            adj.second_down   <= set_hit && rise_q[BTN_SEC_DOWN];
            adj.toggle_12h    <= set_hit && rise_q[BTN_12_24];
            adj.country_valid <= country_hit &&
                                 (rise_q[BTN_JPN] || rise_q[BTN_CHN] || rise_q[BTN_USA]);
            if (rise_q[BTN_CHN]) begin
                adj.country <= CHN;
            end else if (rise_q[BTN_USA]) begin
                adj.country <= USA;
            end else begin
                adj.country <= JPN;
            end
        end
    end

endmodule

//--- clock_pkg.sv
package clock_pkg;

    typedef logic [4:0] hour_t;    // 0 to 23
    typedef logic [5:0] min_sec_t; // 0 to 59

    // Order matches the country buttons
    typedef enum logic [1:0] {
        JPN,
        CHN,
        USA
    } country_e;

    localparam int MODE_WIDTH   = 7;
    localparam int BUTTON_WIDTH = 12;

    // Set wins over country select
    localparam int MODE_SET_BIT     = 6;
    localparam int MODE_COUNTRY_BIT = 5;

    localparam int BTN_HOUR_DOWN = 11;
    localparam int BTN_HOUR_UP   = 9;
    localparam int BTN_MIN_DOWN  = 8;
    localparam int BTN_MIN_UP    = 6;
    localparam int BTN_SEC_DOWN  = 5;
    localparam int BTN_SEC_UP    = 3;
    localparam int BTN_12_24     = 1;

    // Country select mode
    localparam int BTN_JPN = 11;
    localparam int BTN_CHN = 10;
    localparam int BTN_USA = 9;

    localparam logic [7:0] LCD_FUNCTION_SET = 8'h38; // 8-bit bus, 2 lines
    localparam logic [7:0] LCD_DISPLAY_ON   = 8'h0C;
    localparam logic [7:0] LCD_ENTRY_MODE   = 8'h06;
    localparam logic [7:0] LCD_HOME         = 8'h02;
    localparam logic [7:0] LCD_CLEAR        = 8'h01;
    localparam logic [7:0] LCD_ROW1         = 8'h80;
    localparam logic [7:0] LCD_ROW2         = 8'hC0;

    localparam logic [7:0] ASCII_ZERO  = 8'h30;
    localparam logic [7:0] ASCII_SPACE = 8'h20;
    localparam logic [7:0] ASCII_COLON = 8'h3A;

endpackage

//--- clock_state_if.sv
interface clock_state_if;
    import clock_pkg::*;

    hour_t hour;
    min_sec_t minute;
    min_sec_t second;
    country_e country;
    logic hour_12;      // 12-hour display

    modport keeper (
        output hour,
        output minute,
        output second,
        output country,
        output hour_12
    );

    modport display (
        input hour,
        input minute,
        input second,
        input country,
        input hour_12
    );

endinterface

//--- lcd_writer.sv
module lcd_writer (
    input  logic clock,
    input  logic reset,
    input  logic run,
    clock_state_if.display state,
    output logic lcd_rs,
    output logic lcd_rw,
    output logic [7:0] lcd_data
);
    import clock_pkg::*;

    typedef enum logic [2:0] {
        INIT_WAIT,
        INIT_FUNCTION,
        INIT_DISPLAY,
        INIT_ENTRY,
        WRITE,
        IDLE,
        HOME,
        CLEAR
    } phase_e;

    localparam int ROW_CHARS = 15;
    localparam logic [6:0] INIT_WAIT_LAST = 7'd70;
    localparam logic [6:0] INIT_CMD_LAST  = 7'd30;
    localparam logic [6:0] WRITE_LAST     = 7'd40;
    localparam logic [6:0] REFRESH_LAST   = 7'd5;
    localparam logic [6:0] ROW2_SLOT      = 7'd16;
    localparam logic [6:0] LAST_CHAR_SLOT = 7'd31;
    localparam logic [9:0] IDLE_WORD      = 10'b11_0000_0000; // rs=rw=1, bus released

    phase_e phase;
    logic [6:0] count;
    hour_t prev_hour;
    min_sec_t prev_minute;
    min_sec_t prev_second;
    country_e prev_country;
    logic prev_hour_12;
    logic prev_run;
    logic changed;
    hour_t foreign_hour;
    logic [8*ROW_CHARS-1:0] row1;
    logic [8*ROW_CHARS-1:0] row2;
    logic [8*ROW_CHARS-1:0] row_shifted;
    logic [3:0] char_index;
    logic [7:0] row_char;

    function automatic logic [15:0] two_digits(logic [5:0] value);
        return {ASCII_ZERO + 8'(value / 6'd10), ASCII_ZERO + 8'(value % 6'd10)};
    endfunction

    // "NNN hh:mm:ss XM"
    function automatic logic [8*ROW_CHARS-1:0] format_row(
        logic [23:0] name,
        hour_t hour,
        min_sec_t minute,
        min_sec_t second,
        logic hour_12
    );
        hour_t shown;
        logic [15:0] suffix;
        shown  = hour;
        suffix = {ASCII_SPACE, ASCII_SPACE};
        if (hour_12) begin
            if (hour == 5'd0) begin
                shown = 5'd12;
            end else if (hour > 5'd12) begin
                shown = hour - 5'd12;
            end
            suffix = (hour < 5'd12) ? "AM" : "PM";
        end
        return {name, ASCII_SPACE, two_digits(6'(shown)), ASCII_COLON,
                two_digits(minute), ASCII_COLON, two_digits(second),
                ASCII_SPACE, suffix};
    endfunction

    function automatic logic [23:0] country_name(country_e country);
        case (country)
            CHN:     return "CHN";
            USA:     return "USA";
            default: return "JPN";
        endcase
    endfunction

    function automatic hour_t shift_hour(hour_t hour, country_e country);
        logic [5:0] offset;
        case (country)
            CHN:     offset = 6'd1;
            USA:     offset = 6'd14;
            default: offset = 6'd0;
        endcase
        return hour_t'((6'(hour) + 6'd24 - offset) % 6'd24);
    endfunction

    assign foreign_hour = shift_hour(state.hour, state.country);
    assign row1 = format_row("KOR", state.hour, state.minute, state.second, state.hour_12);
    assign row2 = format_row(country_name(state.country), foreign_hour,
                             state.minute, state.second, state.hour_12);

    // Character slots 1..15 and 17..31, slot 17 wraps to index 0
    assign char_index  = 4'(count - 7'd1);
    assign row_shifted = ((count > ROW2_SLOT) ? row2 : row1) << (8 * char_index);
    assign row_char    = row_shifted[8*ROW_CHARS-1 -: 8];

    assign changed = (state.hour != prev_hour) || (state.minute != prev_minute) ||
                     (state.second != prev_second) || (state.country != prev_country) ||
                     (state.hour_12 != prev_hour_12) || (run != prev_run);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            phase        <= INIT_WAIT;
            count        <= '0;
            prev_hour    <= '0;
            prev_minute  <= '0;
            prev_second  <= '0;
            prev_country <= JPN;
            prev_hour_12 <= 1'b0;
            prev_run     <= 1'b0;
        end else begin
            count        <= count + 7'd1;
            prev_hour    <= state.hour;
            prev_minute  <= state.minute;
            prev_second  <= state.second;
            prev_country <= state.country;
            prev_hour_12 <= state.hour_12;
            prev_run     <= run;
            case (phase)
                INIT_WAIT: begin
                    if (count == INIT_WAIT_LAST) begin
                        count <= '0;
                        phase <= INIT_FUNCTION;
                    end
                end
                INIT_FUNCTION, INIT_DISPLAY, INIT_ENTRY: begin
                    if (count == INIT_CMD_LAST) begin
                        count <= '0;
                        phase <= (phase == INIT_FUNCTION) ? INIT_DISPLAY :
                                 (phase == INIT_DISPLAY) ? INIT_ENTRY : WRITE;
                    end
                end
                WRITE: begin
                    if (count == WRITE_LAST) begin
                        count <= '0;
                        phase <= IDLE;
                    end
                end
                IDLE: begin
                    count <= '0;
                    if (changed) begin
                        phase <= HOME;
                    end
                end
                HOME, CLEAR: begin
                    if (count == REFRESH_LAST) begin
                        count <= '0;
                        phase <= (phase == HOME) ? CLEAR : WRITE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            {lcd_rs, lcd_rw, lcd_data} <= {2'b00, ASCII_ZERO};
        end else begin
            case (phase)
                INIT_WAIT, IDLE: {lcd_rs, lcd_rw, lcd_data} <= IDLE_WORD;
                INIT_FUNCTION:   {lcd_rs, lcd_rw, lcd_data} <= {2'b00, LCD_FUNCTION_SET};
                INIT_DISPLAY:    {lcd_rs, lcd_rw, lcd_data} <= {2'b00, LCD_DISPLAY_ON};
                INIT_ENTRY:      {lcd_rs, lcd_rw, lcd_data} <= {2'b00, LCD_ENTRY_MODE};
                HOME:            {lcd_rs, lcd_rw, lcd_data} <= {2'b00, LCD_HOME};
                CLEAR:           {lcd_rs, lcd_rw, lcd_data} <= {2'b00, LCD_CLEAR};
                WRITE: begin
                    if (count == 7'd0) begin
                        {lcd_rs, lcd_rw, lcd_data} <= {2'b00, LCD_ROW1};
                    end else if (count == ROW2_SLOT) begin
                        {lcd_rs, lcd_rw, lcd_data} <= {2'b00, LCD_ROW2};
                    end else if (count <= LAST_CHAR_SLOT) begin
                        {lcd_rs, lcd_rw, lcd_data} <= {2'b10, row_char}; // Data write
                    end else begin
                        {lcd_rs, lcd_rw, lcd_data} <= IDLE_WORD;
                    end
                end
            endcase
        end
    end

endmodule

//--- tb_world_clock.sv
module tb_world_clock;
    timeunit 1ns;
    timeprecision 1ps;
    import clock_pkg::*;

    localparam int TICKS = 8;
    localparam int PASS_CYCLES = 41;  // Write pass length from ROW1
    // Init, time set, run, toggle, country, then margin
    localparam int CYCLE_LIMIT = 250 + 2500 + 300 + 1150 + 200 + 500;

    logic clock;
    logic reset;
    logic [MODE_WIDTH-1:0] mode;
    logic [BUTTON_WIDTH-1:0] button;
    logic lcd_e;
    logic lcd_rs;
    logic lcd_rw;
    logic [7:0] lcd_data;
    logic [19:0] lfsr_state;
    int cycles;
    int tests_done;

    world_clock #(
        .TICKS_PER_SECOND (TICKS)
    ) i_world_clock (
        .clock    (clock),
        .reset    (reset),
        .mode     (mode),
        .button   (button),
        .lcd_e    (lcd_e),
        .lcd_rs   (lcd_rs),
        .lcd_rw   (lcd_rw),
        .lcd_data (lcd_data)
    );

    bind world_clock world_clock_checker #(
        .TICKS_PER_SECOND (TICKS_PER_SECOND)
    ) i_checker (.*);

    function logic next_bit();
        next_bit = lfsr_state[0];
        lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 20'h90000) : (lfsr_state >> 1);
    endfunction

    function int random_bits(int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(next_bit());
        end
        return value;
    endfunction

    task automatic wait_cycles(int n);
        repeat (n) @(posedge clock);
        #1;
    endtask

    task automatic press(int index, int hold);
        button[index] = 1'b1;
        wait_cycles(hold);
        button[index] = 1'b0;
        wait_cycles(3);
    endtask

    task automatic apply_reset();
        reset = 1'b0;
        wait_cycles(16);
        reset = 1'b1;
    endtask

    task automatic wait_row1();
        do begin
            wait_cycles(1);
        end while (!(lcd_rs == 1'b0 && lcd_rw == 1'b0 && lcd_data == LCD_ROW1));
    endtask

    task automatic wait_pass();
        wait_row1();
        wait_cycles(PASS_CYCLES);
    endtask

    task automatic report(string name);
        tests_done++;
        $display("test %s finished, failed checks so far %0d",
                 name, i_world_clock.i_checker.error_count);
    endtask

    initial begin
        clock = 1'b0;
        forever #5 clock = !clock;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles == CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin
        int step_buttons[6];
        int pick;
        step_buttons = '{BTN_HOUR_DOWN, BTN_HOUR_UP, BTN_MIN_DOWN,
                         BTN_MIN_UP, BTN_SEC_DOWN, BTN_SEC_UP};
        reset = 1'b0;
        mode = '0;
        button = '0;
        lfsr_state = 20'd79720;
        cycles = 0;
        tests_done = 0;

        apply_reset();
        wait_pass();
        report("init_order");

        mode = 7'(1 << MODE_SET_BIT);
        wait_pass();                   // Rewrite for the mode change
        for (int i = 0; i < 40; i++) begin
            pick = random_bits(3) % 6;
            press(step_buttons[pick], 1 + random_bits(2));
            wait_pass();
        end
        button[BTN_HOUR_UP] = 1'b1;    // Two at once give nothing
        button[BTN_MIN_UP] = 1'b1;
        wait_cycles(2);
        button = '0;
        wait_cycles(3);
        report("time_set");

        mode = '0;
        repeat (4) begin
            wait_pass();
        end
        report("run");

        mode = 7'(1 << MODE_SET_BIT);
        apply_reset();
        wait_pass();
        press(BTN_12_24, 1);         // 12 AM at hour 0
        wait_pass();
        for (int i = 0; i < 12; i++) begin
            press(BTN_HOUR_UP, 1);
            wait_pass();
        end
        press(BTN_HOUR_UP, 1);       // 01 PM
        wait_pass();
        press(BTN_12_24, 2);
        wait_pass();
        report("toggle_12_24");

        mode = 7'(1 << MODE_COUNTRY_BIT);
        wait_cycles(3);
        press(BTN_CHN, 1);
        wait_pass();
        press(BTN_USA, 2);           // Hour 13 wraps to 23
        wait_pass();
        press(BTN_JPN, 1);
        wait_pass();
        report("country");

        $display("tests run %0d, failed checks %0d",
                 tests_done, i_world_clock.i_checker.error_count);
        if (i_world_clock.i_checker.error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- time_keeper.sv
module time_keeper #(
    parameter int TICKS_PER_SECOND = 1000
) (
    input  logic clock,
    input  logic reset,
    adjust_if.keeper adj,
    clock_state_if.keeper state
);
    import clock_pkg::*;

    localparam int TICK_WIDTH = $clog2(TICKS_PER_SECOND + 1);
    localparam logic [TICK_WIDTH-1:0] LAST_TICK = TICK_WIDTH'(TICKS_PER_SECOND - 1);

    logic [TICK_WIDTH-1:0] tick;
    hour_t hour;
    min_sec_t minute;
    min_sec_t second;
    country_e country;
    logic hour_12;

    function automatic hour_t step_hour(hour_t value, logic up);
        if (up) begin
            return (value == 5'd23) ? 5'd0 : value + 5'd1;
        end
        return (value == 5'd0) ? 5'd23 : value - 5'd1;
    endfunction

    function automatic min_sec_t step_min_sec(min_sec_t value, logic up);
        if (up) begin
            return (value == 6'd59) ? 6'd0 : value + 6'd1;
        end
        return (value == 6'd0) ? 6'd59 : value - 6'd1;
    endfunction

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            tick    <= '0;
            hour    <= '0;
            minute  <= '0;
            second  <= '0;
            country <= JPN;
            hour_12 <= 1'b0;
        end else if (adj.run) begin
            if (tick == LAST_TICK) begin
                tick   <= '0;
                second <= step_min_sec(second, 1'b1);
                if (second == 6'd59) begin   // Carry into minute
                    minute <= step_min_sec(minute, 1'b1);
                    if (minute == 6'd59) begin
                        hour <= step_hour(hour, 1'b1);
                    end
                end
            end else begin
                tick <= tick + 1'b1;
            end
        end else begin
            // At most one pulse per cycle
            if (adj.hour_up || adj.hour_down) begin
                hour <= step_hour(hour, adj.hour_up);
            end
            if (adj.minute_up || adj.minute_down) begin
                minute <= step_min_sec(minute, adj.minute_up);
            end
            if (adj.second_up || adj.second_down) begin
                second <= step_min_sec(second, adj.second_up);
            end
            if (adj.toggle_12h) begin
                hour_12 <= !hour_12;
            end
            if (adj.country_valid) begin
                country <= adj.country;
            end
        end
    end

    assign state.hour    = hour;
    assign state.minute  = minute;
    assign state.second  = second;
    assign state.country = country;
    assign state.hour_12 = hour_12;

endmodule

//--- world_clock.sv
module world_clock #(
    parameter int TICKS_PER_SECOND = 1000
) (
    input  logic clock,
    input  logic reset,
    input  logic [clock_pkg::MODE_WIDTH-1:0] mode,
    input  logic [clock_pkg::BUTTON_WIDTH-1:0] button,
    output logic lcd_e,
    output logic lcd_rs,
    output logic lcd_rw,
    output logic [7:0] lcd_data
);

    adjust_if adj ();
    clock_state_if clock_state ();

    // Enable strobes every cycle
    assign lcd_e = clock;

    button_decoder i_button_decoder (
        .clock  (clock),
        .reset  (reset),
        .mode   (mode),
        .button (button),
        .adj    (adj)
    );

    time_keeper #(
        .TICKS_PER_SECOND (TICKS_PER_SECOND)
    ) i_time_keeper (
        .clock (clock),
        .reset (reset),
        .adj   (adj),
        .state (clock_state)
    );

    lcd_writer i_lcd_writer (
        .clock    (clock),
        .reset    (reset),
        .run      (adj.run),
        .state    (clock_state),
        .lcd_rs   (lcd_rs),
        .lcd_rw   (lcd_rw),
        .lcd_data (lcd_data)
    );

endmodule

//--- world_clock_checker.sv
module world_clock_checker #(
    parameter int TICKS_PER_SECOND = 1000
) (
    input logic clock,
    input logic reset,
    input logic [clock_pkg::MODE_WIDTH-1:0] mode,
    input logic [clock_pkg::BUTTON_WIDTH-1:0] button,
    input logic lcd_e,
    input logic lcd_rs,
    input logic lcd_rw,
    input logic [7:0] lcd_data
);
    timeunit 1ns;
    timeprecision 1ps;
    import clock_pkg::*;

    int error_count = 0;
    logic [8:0] cyc;              // Words since reset release, saturating
    logic [5:0] pos;              // Word position after ROW1
    logic [BUTTON_WIDTH-1:0] button_q;
    logic [BUTTON_WIDTH-1:0] rise_d;
    logic [BUTTON_WIDTH-1:0] set_pend;
    logic [BUTTON_WIDTH-1:0] country_pend;
    logic run_d;
    int tick;
    int m_hour;
    int m_minute;
    int m_second;
    int m_country;
    logic m_hour_12;
    int d_hour;                   // Model one cycle late, as shown on the bus
    int d_minute;
    int d_second;
    int d_country;
    logic d_hour_12;
    logic [7:0] expected;

    function automatic logic [7:0] digit(int value);
        return 8'(int'(ASCII_ZERO) + value);
    endfunction

    function automatic logic [7:0] field_char(int idx, logic [23:0] name, int h,
                                              int m, int s, logic h12);
        int shown;
        shown = h;
        if (h12 && h == 0) begin
            shown = 12;
        end else if (h12 && h > 12) begin
            shown = h - 12;
        end
        case (idx)
            1: return name[23:16];
            2: return name[15:8];
            3: return name[7:0];
            5: return digit(shown / 10);
            6: return digit(shown % 10);
            8: return digit(m / 10);
            9: return digit(m % 10);
            11: return digit(s / 10);
            12: return digit(s % 10);
            7, 10: return ASCII_COLON;
            14: return h12 ? ((h < 12) ? 8'h41 : 8'h50) : ASCII_SPACE; // A or P
            15: return h12 ? 8'h4D : ASCII_SPACE;
            default: return ASCII_SPACE;
        endcase
    endfunction

    function automatic logic [23:0] zone_name(int c);
        return (c == 1) ? "CHN" : (c == 2) ? "USA" : "JPN";
    endfunction

    function automatic int zone_hour(int h, int c);
        return (h + 24 - ((c == 1) ? 1 : (c == 2) ? 14 : 0)) % 24;
    endfunction

    function automatic logic [7:0] init_word(logic [8:0] n);
        if (n <= 9'd102) begin
            return LCD_FUNCTION_SET;
        end else if (n <= 9'd133) begin
            return LCD_DISPLAY_ON;
        end
        return LCD_ENTRY_MODE;
    endfunction

    always_comb begin
        if (pos >= 6'd1 && pos <= 6'd15) begin
            expected = field_char(int'(pos), "KOR", d_hour, d_minute, d_second, d_hour_12);
        end else if (pos >= 6'd17 && pos <= 6'd31) begin
            expected = field_char(int'(pos) - 16, zone_name(d_country),
                                  zone_hour(d_hour, d_country), d_minute, d_second, d_hour_12);
        end else begin
            expected = 8'hFF;     // No character belongs here
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            cyc <= '0;
            pos <= 6'd63;
        end else begin
            if (cyc != 9'd511) begin
                cyc <= cyc + 9'd1;
            end
            if (!lcd_rs && !lcd_rw && lcd_data == LCD_ROW1) begin
                pos <= 6'd1;
            end else if (pos != 6'd63) begin
                pos <= pos + 6'd1;
            end
        end
    end

    // Time model: edge seen, then pulse, then field update
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            button_q <= '0;
            rise_d <= '0;
            set_pend <= '0;
            country_pend <= '0;
            run_d <= 1'b0;
            tick <= 0;
            m_hour <= 0;
            m_minute <= 0;
            m_second <= 0;
            m_country <= 0;
            m_hour_12 <= 1'b0;
        end else begin
            button_q <= button;
            rise_d <= button & ~button_q;
            run_d <= !mode[MODE_SET_BIT] && !mode[MODE_COUNTRY_BIT];
            set_pend <= (mode[MODE_SET_BIT] && $onehot(rise_d)) ? rise_d : '0;
            country_pend <= (!mode[MODE_SET_BIT] && mode[MODE_COUNTRY_BIT] &&
                             $onehot(rise_d)) ? rise_d : '0;
            if (run_d) begin
                tick <= (tick == TICKS_PER_SECOND - 1) ? 0 : tick + 1;
                if (tick == TICKS_PER_SECOND - 1) begin
                    m_second <= (m_second + 1) % 60;
                    if (m_second == 59) begin
                        m_minute <= (m_minute + 1) % 60;
                        if (m_minute == 59) begin
                            m_hour <= (m_hour + 1) % 24;
                        end
                    end
                end
            end else begin
                if (set_pend[BTN_HOUR_UP]) m_hour <= (m_hour + 1) % 24;
                if (set_pend[BTN_HOUR_DOWN]) m_hour <= (m_hour + 23) % 24;
                if (set_pend[BTN_MIN_UP]) m_minute <= (m_minute + 1) % 60;
                if (set_pend[BTN_MIN_DOWN]) m_minute <= (m_minute + 59) % 60;
                if (set_pend[BTN_SEC_UP]) m_second <= (m_second + 1) % 60;
                if (set_pend[BTN_SEC_DOWN]) m_second <= (m_second + 59) % 60;
                if (set_pend[BTN_12_24]) m_hour_12 <= !m_hour_12;
                if (country_pend[BTN_JPN]) m_country <= 0;
                if (country_pend[BTN_CHN]) m_country <= 1;
                if (country_pend[BTN_USA]) m_country <= 2;
            end
        end
    end

    always_ff @(posedge clock) begin
        d_hour <= m_hour;
        d_minute <= m_minute;
        d_second <= m_second;
        d_country <= m_country;
        d_hour_12 <= m_hour_12;
    end

    // Enable is low just before each rising edge
    enable_low: assert property (@(posedge clock) disable iff (!reset) !lcd_e)
    else begin
        $error("** Error %0t lcd_e got %b expected 0", $time, $sampled(lcd_e));
        error_count++;
    end

    enable_high: assert property (@(negedge clock) disable iff (!reset) lcd_e)
    else begin
        $error("** Error %0t lcd_e got %b expected 1", $time, $sampled(lcd_e));
        error_count++;
    end

    init_wait: assert property (@(posedge clock) disable iff (!reset)
        (cyc >= 9'd1 && cyc <= 9'd71) |-> (lcd_rs && lcd_rw && lcd_data == 8'h00))
    else begin
        $error("** Error %0t init bus not released, lcd_data got %h expected 00",
               $time, $sampled(lcd_data));
        error_count++;
    end

    init_commands: assert property (@(posedge clock) disable iff (!reset)
        (cyc >= 9'd72 && cyc <= 9'd164) |-> (!lcd_rs && !lcd_rw && lcd_data == init_word(cyc)))
    else begin
        $error("** Error %0t init lcd_data got %h expected %h",
               $time, $sampled(lcd_data), init_word($sampled(cyc)));
        error_count++;
    end

    first_row: assert property (@(posedge clock) disable iff (!reset)
        (cyc == 9'd165) |-> (!lcd_rs && !lcd_rw && lcd_data == LCD_ROW1))
    else begin
        $error("** Error %0t first pass lcd_data got %h expected %h",
               $time, $sampled(lcd_data), LCD_ROW1);
        error_count++;
    end

    refresh_order: assert property (@(posedge clock) disable iff (!reset)
        (cyc > 9'd165 && !lcd_rs && !lcd_rw && lcd_data == LCD_ROW1) |->
        ($past(lcd_data, 1) == LCD_CLEAR && $past(lcd_data, 6) == LCD_CLEAR &&
         $past(lcd_data, 7) == LCD_HOME && $past(lcd_data, 12) == LCD_HOME))
    else begin
        $error("Rewrite at %0t was not preceded by HOME then CLEAR", $time);
        error_count++;
    end

    row2_slot: assert property (@(posedge clock) disable iff (!reset)
        (!lcd_rs && !lcd_rw && lcd_data == LCD_ROW2) |-> (pos == 6'd16))
    else begin
        $error("** Error %0t ROW2 position got %0d expected 16", $time, $sampled(pos));
        error_count++;
    end

    // Also catches writes while idle
    char_match: assert property (@(posedge clock) disable iff (!reset)
        (lcd_rs && !lcd_rw) |-> (lcd_data == expected))
    else begin
        $error("** Error %0t lcd_data at position %0d got %h expected %h",
               $time, $sampled(pos), $sampled(lcd_data), $sampled(expected));
        error_count++;
    end

endmodule
